// File: fetch_pkg.sv
// Fetch package: word and fetch-to-execute types, reset PC and BTB geometry
`default_nettype none

package fetch_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Fetch-to-execute pipeline register, 98 bits
  // Token marks a valid instruction, a bubble has token 0
  typedef struct packed {
    logic  token;
    word_t pc;
    // Address of the next sequential instruction
    word_t pc4;
    word_t instr;
    // Set when the BTB steered the fetch after this one
    logic  prediction;
  } fetch_ex_t;

  // PC value out of reset
  localparam word_t RESET_PC = 32'h80000000;

  // Direct-mapped BTB, one entry per set
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W = 4;

  // Tag covers the PC bits above the index and the byte offset
  localparam int BTB_TAG_W = 32 - BTB_IDX_W - 2;

endpackage

`default_nettype wire

// File: fetch_hazard_if.sv
// Fetch hazard interface: status from fetch and pipeline controls from the hazard unit
`timescale 1ns/1ns
`default_nettype none

interface fetch_hazard_if;

  // Status from the fetch stage
  logic i_mem_busy;
  logic mal_insn;
  // Trap or branch redirect in this cycle
  logic redirect;

  // Controls back to the fetch stage
  logic pc_en;
  logic if_ex_stall;
  logic if_ex_flush;
  logic iren;

  modport fetch (
    output i_mem_busy, mal_insn, redirect,
    input  pc_en, if_ex_stall, if_ex_flush, iren
  );

  modport hazard (
    input  i_mem_busy, mal_insn, redirect,
    output pc_en, if_ex_stall, if_ex_flush, iren
  );

endinterface

`default_nettype wire

// File: imem_bus_if.sv
// Instruction bus: address and read request out, read data and wait state back
`timescale 1ns/1ns
`default_nettype none

interface imem_bus_if;
  import fetch_pkg::*;

  word_t addr;
  logic  ren;
  // Valid when ren is high and busy is low
  word_t rdata;
  logic  busy;

  modport cpu (
    output addr, ren,
    input  rdata, busy
  );

  modport top (
    input  addr, ren,
    output rdata, busy
  );

endinterface

`default_nettype wire

// File: predictor_if.sv
// Predictor interface: same-cycle BTB lookup from fetch and branch updates from execute
`timescale 1ns/1ns
`default_nettype none

interface predictor_if;
  import fetch_pkg::*;

  // Lookup side
  word_t current_pc;
  logic  predict_taken;
  word_t target_addr;

  // Update side, sampled at the edge while upd_en is high
  logic  upd_en;
  word_t upd_pc;
  logic  upd_taken;
  word_t upd_target;

  modport access (
    output current_pc,
    input  predict_taken, target_addr
  );

  modport predictor (
    input  current_pc,
    input  upd_en, upd_pc, upd_taken, upd_target,
    output predict_taken, target_addr
  );

endinterface

`default_nettype wire

// File: tspp_fetch_stage.sv
// Fetch stage: PC, next-PC select, bus request, fetch-to-execute register and misalign check
`timescale 1ns/1ns
`default_nettype none

module tspp_fetch_stage (
  input  logic                CLK,
  input  logic                nRST,
  fetch_hazard_if.fetch       hazard_if,
  imem_bus_if.cpu             bus_if,
  predictor_if.access         predict_if,
  input  logic                npc_sel,
  input  fetch_pkg::word_t    brj_addr,
  input  logic                trap_req,
  input  fetch_pkg::word_t    trap_pc,
  output fetch_pkg::fetch_ex_t fetch_ex_reg,
  output logic                fetch_fault,
  output fetch_pkg::word_t    fault_addr
);
  import fetch_pkg::*;

  word_t pc;
  word_t pc4;
  word_t npc;
  logic  mal_addr;

  // Pipeline register fields
  logic  ex_token_q;
  word_t ex_pc_q;
  word_t ex_pc4_q;
  word_t ex_instr_q;
  logic  ex_pred_q;

  // Program counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (hazard_if.pc_en) begin
      pc <= npc;
    end
  end

  assign pc4 = pc + 32'd4;

  // BTB lookup on the current PC
  assign predict_if.current_pc = pc;

  // Next PC, trap first, then branch, then prediction
  always_comb begin
    if (trap_req) begin
      npc = trap_pc;
    end else if (npc_sel) begin
      npc = brj_addr;
    end else if (predict_if.predict_taken) begin
      npc = predict_if.target_addr;
    end else begin
      npc = pc4;
    end
  end

  assign hazard_if.redirect = trap_req | npc_sel;

  // Bus request straight from the PC
  assign bus_if.addr = pc;
  assign bus_if.ren = hazard_if.iren;
  assign hazard_if.i_mem_busy = bus_if.busy;

  // Token: flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_token_q <= 1'b0;
    end else if (hazard_if.if_ex_flush) begin
      ex_token_q <= 1'b0;
    end else if (!hazard_if.if_ex_stall) begin
      ex_token_q <= 1'b1;
    end
  end

  // Payload only moves on a capture
  always_ff @(posedge CLK) begin
    if (!hazard_if.if_ex_flush && !hazard_if.if_ex_stall) begin
      ex_pc_q    <= pc;
      ex_pc4_q   <= pc4;
      ex_instr_q <= bus_if.rdata;
      ex_pred_q  <= predict_if.predict_taken;
    end
  end

  assign fetch_ex_reg = '{
    token:      ex_token_q,
    pc:         ex_pc_q,
    pc4:        ex_pc4_q,
    instr:      ex_instr_q,
    prediction: ex_pred_q
  };

  // Misaligned PC, fetch parks here until a trap
  assign mal_addr = (pc[1:0] != 2'b00);
  assign hazard_if.mal_insn = mal_addr;
  assign fetch_fault = mal_addr;
  assign fault_addr = pc;

endmodule

`default_nettype wire

// File: btb_predictor.sv
// Branch target buffer: direct-mapped, 2-bit counters, trained by execute
`timescale 1ns/1ns
`default_nettype none

module btb_predictor (
  input  logic           CLK,
  input  logic           nRST,
  predictor_if.predictor predict_if
);
  import fetch_pkg::*;

  // Table storage
  logic [BTB_ENTRIES-1:0] valid;
  logic [BTB_TAG_W-1:0]   tag_mem [BTB_ENTRIES];
  word_t                  target_mem [BTB_ENTRIES];
  logic [1:0]             cnt_mem [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] rd_idx;
  logic [BTB_TAG_W-1:0] rd_tag;
  logic [BTB_IDX_W-1:0] wr_idx;
  logic [BTB_TAG_W-1:0] wr_tag;
  logic                 rd_hit;
  logic                 wr_hit;

  // Index from PC bits 5 to 2, tag from the rest
  assign rd_idx = predict_if.current_pc[BTB_IDX_W+1:2];
  assign rd_tag = predict_if.current_pc[31:BTB_IDX_W+2];
  assign wr_idx = predict_if.upd_pc[BTB_IDX_W+1:2];
  assign wr_tag = predict_if.upd_pc[31:BTB_IDX_W+2];

  // Same-cycle lookup
  assign rd_hit = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign predict_if.predict_taken = rd_hit && cnt_mem[rd_idx][1];
  assign predict_if.target_addr = target_mem[rd_idx];

  assign wr_hit = valid[wr_idx] && (tag_mem[wr_idx] == wr_tag);

  // Valid bits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (predict_if.upd_en && predict_if.upd_taken && !wr_hit) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // Tag, target and counter
  always_ff @(posedge CLK) begin
    if (predict_if.upd_en) begin
      if (wr_hit) begin
        // Saturating counter step
        if (predict_if.upd_taken) begin
          if (cnt_mem[wr_idx] != 2'd3) begin
            cnt_mem[wr_idx] <= cnt_mem[wr_idx] + 2'd1;
          end
          target_mem[wr_idx] <= predict_if.upd_target;
        end else if (cnt_mem[wr_idx] != 2'd0) begin
          cnt_mem[wr_idx] <= cnt_mem[wr_idx] - 2'd1;
        end
      end else if (predict_if.upd_taken) begin
        // Allocate as weakly taken
        tag_mem[wr_idx]    <= wr_tag;
        target_mem[wr_idx] <= predict_if.upd_target;
        cnt_mem[wr_idx]    <= 2'd2;
      end
    end
  end

endmodule

`default_nettype wire

// File: fetch_hazard_unit.sv
// Fetch hazard unit: PC enable, register stall and flush, bus read enable
`timescale 1ns/1ns
`default_nettype none

module fetch_hazard_unit (
  fetch_hazard_if.hazard hazard_if,
  input  logic           ex_stall
);

  logic busy;
  logic fault;
  logic redirect;

  assign busy = hazard_if.i_mem_busy;
  assign fault = hazard_if.mal_insn;
  assign redirect = hazard_if.redirect;

  // PC moves on a redirect or a completed fetch that execute accepts
  assign hazard_if.pc_en = redirect | (!fault & !busy & !ex_stall);

  // Bubble on redirect, wait state or fault
  // Stalled execute keeps its token unless redirected
  assign hazard_if.if_ex_flush = redirect | (!ex_stall & (busy | fault));

  // Execute back-pressure
  // Applied after flush in the fetch register
  assign hazard_if.if_ex_stall = ex_stall;

  // No bus access from a misaligned PC
  assign hazard_if.iren = !fault;

endmodule

`default_nettype wire

// File: fetch_subsystem.sv
// Fetch subsystem top: fetch stage, BTB and hazard unit behind plain ports
`timescale 1ns/1ns
`default_nettype none

module fetch_subsystem (
  input  logic             CLK,
  input  logic             nRST,
  // Instruction bus
  output fetch_pkg::word_t imem_addr,
  output logic             imem_ren,
  input  fetch_pkg::word_t imem_rdata,
  input  logic             imem_busy,
  // Execute side controls
  input  logic             ex_stall,
  input  logic             npc_sel,
  input  fetch_pkg::word_t brj_addr,
  input  logic             trap_req,
  input  fetch_pkg::word_t trap_pc,
  // BTB training
  input  logic             upd_en,
  input  fetch_pkg::word_t upd_pc,
  input  logic             upd_taken,
  input  fetch_pkg::word_t upd_target,
  // Fetch-to-execute register
  output logic             ex_token,
  output fetch_pkg::word_t ex_pc,
  output fetch_pkg::word_t ex_pc4,
  output fetch_pkg::word_t ex_instr,
  output logic             ex_prediction,
  // Misaligned fetch report
  output logic             fetch_fault,
  output fetch_pkg::word_t fault_addr
);
  import fetch_pkg::*;

  fetch_ex_t fetch_ex_reg;

  fetch_hazard_if hazard_bus ();
  imem_bus_if     imem_bus ();
  predictor_if    predict_bus ();

  // Bus to pins
  assign imem_addr = imem_bus.addr;
  assign imem_ren = imem_bus.ren;
  assign imem_bus.rdata = imem_rdata;
  assign imem_bus.busy = imem_busy;

  // Update port goes straight to the BTB
  assign predict_bus.upd_en = upd_en;
  assign predict_bus.upd_pc = upd_pc;
  assign predict_bus.upd_taken = upd_taken;
  assign predict_bus.upd_target = upd_target;

  tspp_fetch_stage fetch_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .hazard_if    (hazard_bus.fetch),
    .bus_if       (imem_bus.cpu),
    .predict_if   (predict_bus.access),
    .npc_sel      (npc_sel),
    .brj_addr     (brj_addr),
    .trap_req     (trap_req),
    .trap_pc      (trap_pc),
    .fetch_ex_reg (fetch_ex_reg),
    .fetch_fault  (fetch_fault),
    .fault_addr   (fault_addr)
  );

  btb_predictor btb_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .predict_if (predict_bus.predictor)
  );

  fetch_hazard_unit hazard_i (
    .hazard_if (hazard_bus.hazard),
    .ex_stall  (ex_stall)
  );

  // Unpack the pipeline register
  assign ex_token = fetch_ex_reg.token;
  assign ex_pc = fetch_ex_reg.pc;
  assign ex_pc4 = fetch_ex_reg.pc4;
  assign ex_instr = fetch_ex_reg.instr;
  assign ex_prediction = fetch_ex_reg.prediction;

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// Testbench clock and reset generator: 4 ns clock, reset low for 4 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    // Hold reset over four rising edges
    repeat (4) @(posedge CLK);
    // Release away from the rising edge
    @(negedge CLK);
    nRST = 1'b1;
  end

  // Half period 2 ns
  always #2 CLK = ~CLK;

endmodule

`default_nettype wire

// File: tb_fetch_assert.sv
// Fetch subsystem assertions: reset token, bus address hold and execute stall hold
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_assert (
  input logic             CLK,
  input logic             nRST,
  input logic             ex_token,
  input logic             imem_busy,
  input logic             ex_stall,
  input logic             npc_sel,
  input logic             trap_req,
  input fetch_pkg::word_t imem_addr,
  input fetch_pkg::word_t ex_pc,
  input fetch_pkg::word_t ex_pc4,
  input fetch_pkg::word_t ex_instr,
  input logic             ex_prediction
);

  // No token in the first cycle out of reset
  token_low_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> !ex_token)
    else $error("ex_token high right after reset");

  // Wait state keeps the request unless redirected
  addr_stable_while_busy: assert property (@(posedge CLK) disable iff (!nRST)
    imem_busy && !(trap_req || npc_sel) |=> $stable(imem_addr))
    else $error("imem_addr moved during a wait state");

  // Back-pressure holds the whole register
  ex_hold_while_stalled: assert property (@(posedge CLK) disable iff (!nRST)
    ex_stall && !(trap_req || npc_sel)
    |=> $stable({ex_token, ex_pc, ex_pc4, ex_instr, ex_prediction}))
    else $error("fetch-to-execute register changed under ex_stall");

endmodule

bind fetch_subsystem tb_fetch_assert assert_i (.*);

`default_nettype wire

// File: tb_fetch.sv
// Fetch subsystem testbench: wait-state memory, stimulus table, reference model and checks
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;
  import fetch_pkg::*;

  localparam word_t MEM_KEY = 32'h13579BDF;
  localparam int WAIT_LIMIT = 200;

  typedef enum {ACT_RUN, ACT_STALL, ACT_BRANCH, ACT_TRAIN, ACT_TRAP} act_e;

  typedef struct {
    string name;
    act_e  act;
    word_t addr;
    logic  taken;
    int    count;
  } row_t;

  logic  CLK;
  logic  nRST;
  word_t imem_addr;
  logic  imem_ren;
  word_t imem_rdata;
  logic  imem_busy;
  logic  ex_stall;
  logic  npc_sel;
  word_t brj_addr;
  logic  trap_req;
  word_t trap_pc;
  logic  upd_en;
  word_t upd_pc;
  logic  upd_taken;
  word_t upd_target;
  logic  ex_token;
  word_t ex_pc;
  word_t ex_pc4;
  word_t ex_instr;
  logic  ex_prediction;
  logic  fetch_fault;
  word_t fault_addr;

  // Memory model state
  word_t req_addr;
  int    waits_left;
  int    fresh_wait;

  // Reference model state
  word_t exp_pc;
  logic  exp_pred;
  logic  prev_stall;
  // Pc of the last token seen
  word_t last_pc;
  // Update seen this cycle, written into the BTB at the coming edge
  logic  pend_en;
  word_t pend_pc;
  logic  pend_taken;
  word_t pend_target;
  logic  m_valid [BTB_ENTRIES];
  logic [BTB_TAG_W-1:0] m_tag [BTB_ENTRIES];
  word_t m_target [BTB_ENTRIES];
  int    m_cnt [BTB_ENTRIES];

  int    tok_count;
  int    err_count;
  int    timeout_count;
  string cur_name;
  row_t  rows [$];

  tb_clk_gen clk_i (
    .CLK  (CLK),
    .nRST (nRST)
  );

  fetch_subsystem dut_i (.*);

  // Combinational read, instruction is address XOR key
  assign imem_rdata = imem_addr ^ MEM_KEY;
  // Fresh address takes its drawn wait count from its first cycle
  assign imem_busy = imem_ren &&
    ((imem_addr != req_addr) ? (fresh_wait != 0) : (waits_left != 0));

  always @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      req_addr <= '1;
      waits_left <= 0;
      fresh_wait <= 0;
    end else if (imem_addr != req_addr) begin
      req_addr <= imem_addr;
      waits_left <= (fresh_wait == 0) ? 0 : fresh_wait - 1;
      fresh_wait <= $urandom % 3;
    end else if (waits_left != 0) begin
      waits_left <= waits_left - 1;
    end
  end

  function automatic int model_idx(input word_t pc);
    return int'(pc[BTB_IDX_W+1:2]);
  endfunction

  // Taken on a valid tag match with a counter of 2 or 3
  function automatic logic model_predict(input word_t pc);
    int i;
    i = model_idx(pc);
    return m_valid[i] && (m_tag[i] == pc[31:BTB_IDX_W+2]) && (m_cnt[i] >= 2);
  endfunction

  task automatic model_update(input word_t pc, input logic taken, input word_t target);
    int i;
    logic hit;
    i = model_idx(pc);
    hit = m_valid[i] && (m_tag[i] == pc[31:BTB_IDX_W+2]);
    if (hit && taken) begin
      m_cnt[i] = (m_cnt[i] < 3) ? m_cnt[i] + 1 : 3;
      m_target[i] = target;
    end else if (hit) begin
      m_cnt[i] = (m_cnt[i] > 0) ? m_cnt[i] - 1 : 0;
    end else if (taken) begin
      // Miss on taken allocates weakly taken
      m_valid[i] = 1'b1;
      m_tag[i] = pc[31:BTB_IDX_W+2];
      m_target[i] = target;
      m_cnt[i] = 2;
    end
  endtask

  task automatic check(input string test, input string field, input word_t expected,
                       input word_t actual);
    if (actual !== expected) begin
      err_count++;
      $display("** Error %s %s: expected %h, actual %h", test, field, expected, actual);
    end
  endtask

  // Outputs settle by the falling edge
  // A token is new when the last edge was not a stall
  always @(negedge CLK) begin
    if (!nRST) begin
      exp_pc = RESET_PC;
      prev_stall = 1'b0;
      pend_en = 1'b0;
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
      end
    end else begin
      if (ex_token && !prev_stall) begin
        exp_pred = model_predict(exp_pc);
        check(cur_name, "pc", exp_pc, ex_pc);
        check(cur_name, "pc4", exp_pc + 32'd4, ex_pc4);
        check(cur_name, "instr", exp_pc ^ MEM_KEY, ex_instr);
        check(cur_name, "prediction", {31'b0, exp_pred}, {31'b0, ex_prediction});
        tok_count++;
        last_pc = exp_pc;
        exp_pc = exp_pred ? m_target[model_idx(exp_pc)] : exp_pc + 32'd4;
      end
      // Redirect lands at the coming edge, trap first
      if (trap_req) begin
        exp_pc = trap_pc;
      end else if (npc_sel) begin
        exp_pc = brj_addr;
      end
      // Written at the last edge, seen from the next lookup on
      if (pend_en) begin
        model_update(pend_pc, pend_taken, pend_target);
      end
      pend_en = upd_en;
      pend_pc = upd_pc;
      pend_taken = upd_taken;
      pend_target = upd_target;
      prev_stall = ex_stall;
    end
  end

  task automatic wait_tokens(input int count);
    int target;
    int n;
    target = tok_count + count;
    n = 0;
    while (tok_count < target && n < WAIT_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    if (tok_count < target) begin
      timeout_count++;
      $display("Timeout in %s: only %0d of %0d tokens arrived", cur_name,
               count - (target - tok_count), count);
    end
  endtask

  task automatic add_row(input string name, input act_e act, input word_t addr,
                         input logic taken, input int count);
    row_t r;
    r.name = name;
    r.act = act;
    r.addr = addr;
    r.taken = taken;
    r.count = count;
    rows.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    int start;
    cur_name = r.name;
    case (r.act)
      ACT_RUN: begin
        @(posedge CLK);
        ex_stall <= 1'b0;
        wait_tokens(r.count);
      end
      ACT_STALL: begin
        @(posedge CLK);
        ex_stall <= 1'b1;
        // One edge for a capture already under way
        @(posedge CLK);
        repeat (r.count) @(posedge CLK);
        check(r.name, "held pc", last_pc, ex_pc);
        ex_stall <= 1'b0;
      end
      ACT_BRANCH: begin
        @(posedge CLK);
        ex_stall <= 1'b0;
        npc_sel <= 1'b1;
        brj_addr <= r.addr;
        @(posedge CLK);
        npc_sel <= 1'b0;
        if (r.addr[1:0] != 2'b00) begin
          // Misaligned target parks fetch
          start = tok_count;
          repeat (4) @(posedge CLK);
          check(r.name, "fetch_fault", 32'd1, {31'b0, fetch_fault});
          check(r.name, "fault_addr", r.addr, fault_addr);
          check(r.name, "imem_ren", 32'd0, {31'b0, imem_ren});
          check(r.name, "token count", start, tok_count);
        end else begin
          wait_tokens(r.count);
        end
      end
      ACT_TRAIN: begin
        @(posedge CLK);
        upd_en <= 1'b1;
        upd_pc <= r.addr;
        upd_taken <= r.taken;
        upd_target <= r.addr + 32'h100;
        @(posedge CLK);
        upd_en <= 1'b0;
      end
      ACT_TRAP: begin
        // Taken bit adds a competing branch in the same cycle
        @(posedge CLK);
        ex_stall <= 1'b0;
        trap_req <= 1'b1;
        trap_pc <= r.addr;
        npc_sel <= r.taken;
        brj_addr <= r.addr + 32'h100;
        @(posedge CLK);
        trap_req <= 1'b0;
        npc_sel <= 1'b0;
        wait_tokens(r.count);
      end
      default: ;
    endcase
  endtask

  initial begin
    int n;
    void'($urandom(62659));
    ex_stall = 1'b0;
    npc_sel = 1'b0;
    brj_addr = '0;
    trap_req = 1'b0;
    trap_pc = '0;
    upd_en = 1'b0;
    upd_pc = '0;
    upd_taken = 1'b0;
    upd_target = '0;
    tok_count = 0;
    err_count = 0;
    timeout_count = 0;
    cur_name = "reset";

    add_row("reset_stream", ACT_RUN, '0, 1'b0, 6);
    add_row("backpressure", ACT_STALL, '0, 1'b0, 5);
    add_row("after_stall", ACT_RUN, '0, 1'b0, 4);
    add_row("branch", ACT_BRANCH, 32'h80000400, 1'b0, 3);
    add_row("train_taken", ACT_TRAIN, 32'h80000810, 1'b1, 0);
    add_row("predict_hit", ACT_BRANCH, 32'h80000808, 1'b0, 4);
    add_row("predict_run", ACT_RUN, '0, 1'b0, 2);
    add_row("train_not_1", ACT_TRAIN, 32'h80000810, 1'b0, 0);
    add_row("train_not_2", ACT_TRAIN, 32'h80000810, 1'b0, 0);
    add_row("predict_off", ACT_BRANCH, 32'h80000808, 1'b0, 4);
    add_row("misaligned", ACT_BRANCH, 32'h80000A02, 1'b0, 0);
    add_row("trap_resume", ACT_TRAP, 32'h80000C00, 1'b0, 3);
    add_row("priority", ACT_TRAP, 32'h80000E00, 1'b1, 3);

    n = 0;
    while (nRST !== 1'b1 && n < WAIT_LIMIT) begin
      @(posedge CLK or posedge nRST);
      n++;
    end
    if (nRST !== 1'b1) begin
      timeout_count++;
      $display("Timeout: reset was never released");
    end else begin
      // First cycle out of reset, no edge yet
      check("reset", "imem_ren", 32'd1, {31'b0, imem_ren});
      check("reset", "imem_addr", RESET_PC, imem_addr);
      check("reset", "fetch_fault", 32'd0, {31'b0, fetch_fault});
      check("reset", "ex_token", 32'd0, {31'b0, ex_token});
    end

    foreach (rows[i]) begin
      if (timeout_count == 0) begin
        apply_row(rows[i]);
      end
    end

    $display("Checked %0d tokens with %0d errors and %0d timeouts",
             tok_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
fetch_pkg.sv
fetch_hazard_if.sv
imem_bus_if.sv
predictor_if.sv
tspp_fetch_stage.sv
btb_predictor.sv
fetch_hazard_unit.sv
fetch_subsystem.sv
tb_clk_gen.sv
tb_fetch_assert.sv
tb_fetch.sv

// File: Makefile
# Verilator build and run of the fetch subsystem testbench

TOP = tb_fetch

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)
	verilator --lint-only -f verilog.f --top-module fetch_subsystem \
		fetch_pkg.sv fetch_hazard_if.sv imem_bus_if.sv predictor_if.sv \
		tspp_fetch_stage.sv btb_predictor.sv fetch_hazard_unit.sv fetch_subsystem.sv

clean:
	rm -rf obj_dir sim.log
